//--- design/net_pkg.sv
package net_pkg;

  //////////////////////////////////////////////////////////////////////
  // Address and field widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [7:0]  byte_t;

  localparam ethertype_t ETH_ARP   = 16'h0806;
  localparam mac_addr_t  ETH_BCAST = 48'hFFFF_FFFF_FFFF;

  // Line framing, no FCS on either side
  localparam byte_t PRE_BYTE    = 8'h55;
  localparam byte_t SFD_BYTE    = 8'hD5;
  localparam int    PRE_LEN     = 7;  // 0x55 bytes before the SFD
  localparam int    HDR_LEN     = 14; // dst, src, ethertype
  localparam int    MIN_PAYLOAD = 46;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // Byte stream, line side uses dat and val only
  typedef struct packed {
    byte_t dat;
    logic  val;
    logic  sof;
    logic  eof;
  } strm_t;

  // Ethernet header as it appears on the line, dst first
  typedef struct packed {
    mac_addr_t  dst;
    mac_addr_t  src;
    ethertype_t etype;
  } mac_meta_t;

endpackage

//--- design/eth_rx.sv
`timescale 1ns/1ps

module eth_rx import net_pkg::*; #(
  parameter mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01
) (
  input  logic      clk,
  input  logic      rst,
  input  strm_t     phy_rx,
  output mac_meta_t meta,
  output logic      meta_val,
  output strm_t     strm
);

  typedef enum logic [2:0] {IDLE, PREAMBLE, HEADER, PAYLOAD, DROP} state_t;

  localparam int HW = $bits(mac_meta_t);

  state_t     state;
  logic [3:0] hdr_cnt;
  mac_meta_t  hdr_nxt;
  logic       accept;
  logic       first;
  byte_t      dly_dat;
  logic       dly_val;
  logic       dly_sof;

  // Header as it will look after the current byte is shifted in
  assign hdr_nxt = {meta[HW-9:0], phy_rx.dat};
  assign accept  = (hdr_nxt.dst == MAC_ADDR) || (hdr_nxt.dst == ETH_BCAST);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      hdr_cnt  <= '0;
      meta_val <= 1'b0;
      first    <= 1'b0;
    end else begin
      meta_val <= 1'b0;
      case (state)
        IDLE: begin
          if (phy_rx.val) begin
            state <= (phy_rx.dat == PRE_BYTE) ? PREAMBLE : DROP;
          end
        end
        PREAMBLE: begin
          hdr_cnt <= '0;
          if (!phy_rx.val) state <= IDLE;
          else if (phy_rx.dat == SFD_BYTE) state <= HEADER;
          else if (phy_rx.dat != PRE_BYTE) state <= DROP; // Broken preamble
        end
        HEADER: begin
          if (!phy_rx.val) begin
            state <= IDLE; // Runt frame
          end else begin
            hdr_cnt <= hdr_cnt + 4'd1;
            if (hdr_cnt == 4'(HDR_LEN - 1)) begin
              meta_val <= accept;
              first    <= 1'b1;
              state    <= accept ? PAYLOAD : DROP;
            end
          end
        end
        PAYLOAD: begin
          if (!phy_rx.val) state <= IDLE;
          else first <= 1'b0;
        end
        DROP: begin
          if (!phy_rx.val) state <= IDLE; // Discard until the line goes quiet
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == HEADER && phy_rx.val) meta <= hdr_nxt;
  end

  ////////////////////////////////////////////////////////////////////////
  // One-byte delay so that eof can be tagged from the next val
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      dly_val <= 1'b0;
      dly_sof <= 1'b0;
    end else begin
      dly_val <= (state == PAYLOAD) && phy_rx.val;
      dly_sof <= (state == PAYLOAD) && phy_rx.val && first;
    end
  end

  always_ff @(posedge clk) begin
    dly_dat <= phy_rx.dat;
  end

  assign strm.dat = dly_dat;
  assign strm.val = dly_val;
  assign strm.sof = dly_sof;
  assign strm.eof = dly_val && !phy_rx.val; // Line went idle behind this byte

  // Header pulse must always precede the first payload byte
  a_meta_before_payload: assert property (@(posedge clk) disable iff (rst)
    !(meta_val && strm.val))
    else $error("eth_rx: meta_val overlaps payload stream");

endmodule

//--- design/arp_resp.sv
`timescale 1ns/1ps

module arp_resp import net_pkg::*; #(
  parameter mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01
) (
  input  logic      clk,
  input  logic      rst,
  input  ipv4_t     ip_addr,
  input  logic      ip_set,
  input  mac_meta_t rx_meta,
  input  logic      rx_meta_val,
  input  strm_t     rx_strm,
  input  logic      req,
  input  logic      done,
  output mac_meta_t tx_meta,
  output logic      rdy,
  output strm_t     tx_strm
);

  localparam int ARP_LEN = 28;

  // ARP body for Ethernet/IPv4, in line order
  typedef struct packed {
    logic [15:0] htype;
    logic [15:0] ptype;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    logic [15:0] oper;
    mac_addr_t   sha;
    ipv4_t       spa;
    mac_addr_t   tha;
    ipv4_t       tpa;
  } arp_body_t;

  localparam int BW = $bits(arp_body_t);

  ipv4_t      dev_ip;
  logic       ip_vld;
  logic       is_arp;
  logic [4:0] rx_cnt;
  arp_body_t  rx_body;
  arp_body_t  body_nxt;
  logic       match;
  logic       pending;
  arp_body_t  tx_body;
  logic [4:0] tx_cnt;

  //////////////////////////////////////////////////////////////////////
  // Device address
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      dev_ip <= '0;
      ip_vld <= 1'b0;
    end else if (ip_set) begin
      dev_ip <= ip_addr;
      ip_vld <= 1'b1; // Responder may answer from now on
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request capture
  //////////////////////////////////////////////////////////////////////

  // Only the first 28 bytes are kept, padding is ignored
  assign body_nxt = (rx_cnt < 5'(ARP_LEN)) ? {rx_body[BW-9:0], rx_strm.dat} : rx_body;

  assign match = rx_strm.val && rx_strm.eof && is_arp && ip_vld && !pending &&
                 (rx_cnt >= 5'(ARP_LEN - 1)) &&
                 (body_nxt.oper == 16'd1) && (body_nxt.tpa == dev_ip);

  always_ff @(posedge clk) begin
    if (rst) begin
      is_arp <= 1'b0;
      rx_cnt <= '0;
    end else if (rx_meta_val) begin
      is_arp <= (rx_meta.etype == ETH_ARP);
      rx_cnt <= '0;
    end else if (rx_strm.val && rx_cnt < 5'(ARP_LEN)) begin
      rx_cnt <= rx_cnt + 5'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_strm.val) rx_body <= body_nxt;
  end

  //////////////////////////////////////////////////////////////////////
  // Reply
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy         <= 1'b0;
      pending     <= 1'b0;
      tx_cnt      <= '0;
      tx_strm.val <= 1'b0;
      tx_strm.sof <= 1'b0;
      tx_strm.eof <= 1'b0;
    end else begin
      if (match) begin
        rdy     <= 1'b1;
        pending <= 1'b1;
        tx_meta <= '{dst: body_nxt.sha, src: MAC_ADDR, etype: ETH_ARP};
        tx_body <= '{htype: 16'd1, ptype: 16'h0800, hlen: 8'd6, plen: 8'd4,
                     oper: 16'd2, sha: MAC_ADDR, spa: dev_ip,
                     tha: body_nxt.sha, tpa: body_nxt.spa};
      end
      if (done) pending <= 1'b0; // Slot free for the next request

      if (req) begin
        rdy         <= 1'b0;
        tx_cnt      <= 5'd1;
        tx_strm.dat <= tx_body[BW-1 -: 8];
        tx_strm.val <= 1'b1;
        tx_strm.sof <= 1'b1;
        tx_strm.eof <= 1'b0;
        tx_body     <= {tx_body[BW-9:0], 8'h00};
      end else if (tx_strm.val) begin
        tx_strm.sof <= 1'b0;
        if (tx_strm.eof) begin
          tx_strm.val <= 1'b0;
          tx_strm.eof <= 1'b0;
        end else begin
          tx_strm.dat <= tx_body[BW-1 -: 8];
          tx_strm.eof <= (tx_cnt == 5'(ARP_LEN - 1));
          tx_cnt      <= tx_cnt + 5'd1;
          tx_body     <= {tx_body[BW-9:0], 8'h00};
        end
      end
    end
  end

  // Arbiter must only forward req to a source that is offering a frame
  a_req_needs_rdy: assert property (@(posedge clk) disable iff (rst) req |-> rdy)
    else $error("arp_resp: req without rdy");

endmodule

//--- design/tx_arb.sv
`timescale 1ns/1ps

module tx_arb import net_pkg::*; #(
  parameter int N = 2
) (
  input  logic         clk,
  input  logic         rst,
  input  mac_meta_t    src_meta [N],
  input  logic [N-1:0] src_rdy,
  input  strm_t        src_strm [N],
  input  logic         req,
  input  logic         done,
  output logic [N-1:0] src_req,
  output logic [N-1:0] src_done,
  output mac_meta_t    meta,
  output logic         rdy,
  output strm_t        strm
);

  localparam int IW = (N > 1) ? $clog2(N) : 1;

  logic [N-1:0]  gnt;
  logic          busy;
  logic [IW-1:0] last;
  logic [IW-1:0] pick;

  // Round robin, nearest requester after the last grant wins
  always_comb begin
    pick = last;
    for (int i = N; i >= 1; i--) begin
      if (src_rdy[(int'(last) + i) % N]) pick = IW'((int'(last) + i) % N);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      gnt  <= '0;
      busy <= 1'b0;
      last <= IW'(N - 1); // Source 0 goes first
    end else if (!busy) begin
      if (|src_rdy) begin
        busy <= 1'b1;
        gnt  <= {{(N-1){1'b0}}, 1'b1} << pick;
        last <= pick;
      end
    end else if (done) begin
      busy <= 1'b0; // Grant held for the whole frame
      gnt  <= '0;
    end
  end

  assign rdy      = |(gnt & src_rdy);
  assign src_req  = gnt & {N{req}};
  assign src_done = gnt & {N{done}};
  assign meta     = src_meta[last];
  assign strm     = src_strm[last];

  a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) busy |-> $onehot(gnt))
    else $error("tx_arb: grant not one-hot while busy");

endmodule

//--- design/eth_tx.sv
`timescale 1ns/1ps

module eth_tx import net_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  mac_meta_t meta,
  input  logic      rdy,
  input  strm_t     strm,
  output logic      req,
  output logic      done,
  output strm_t     phy_tx
);

  typedef enum logic [2:0] {IDLE, PREAMBLE, HEADER, PAYLOAD, PAD, GAP} state_t;

  localparam int GAP_LEN = 12;
  localparam int HW      = $bits(mac_meta_t);

  state_t      state;
  logic [3:0]  cnt;  // Preamble, header and gap position
  logic [10:0] pcnt; // Payload index, up to 1500 bytes
  mac_meta_t   hdr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      cnt        <= '0;
      pcnt       <= '0;
      req        <= 1'b0;
      done       <= 1'b0;
      phy_tx.val <= 1'b0;
      phy_tx.sof <= 1'b0;
      phy_tx.eof <= 1'b0;
    end else begin
      req        <= 1'b0;
      done       <= 1'b0;
      phy_tx.sof <= 1'b0;
      phy_tx.eof <= 1'b0;
      case (state)
        IDLE: begin
          if (rdy) begin
            hdr        <= meta; // Source may drop meta after req
            phy_tx.dat <= PRE_BYTE;
            phy_tx.val <= 1'b1;
            phy_tx.sof <= 1'b1;
            cnt        <= 4'd1;
            state      <= PREAMBLE;
          end
        end
        PREAMBLE: begin
          cnt <= cnt + 4'd1;
          if (cnt == 4'(PRE_LEN)) begin
            phy_tx.dat <= SFD_BYTE;
            cnt        <= '0;
            state      <= HEADER;
          end else begin
            phy_tx.dat <= PRE_BYTE;
          end
        end
        HEADER: begin
          phy_tx.dat <= hdr[HW-1 -: 8];
          hdr        <= {hdr[HW-9:0], 8'h00};
          cnt        <= cnt + 4'd1;
          // Source answers req one cycle late, we sample one more later
          req <= (cnt == 4'(HDR_LEN - 2));
          if (cnt == 4'(HDR_LEN - 1)) begin
            pcnt  <= '0;
            state <= PAYLOAD;
          end
        end
        PAYLOAD: begin
          phy_tx.dat <= strm.dat;
          pcnt       <= pcnt + 11'd1;
          if (strm.eof) begin
            if (pcnt >= 11'(MIN_PAYLOAD - 1)) begin
              phy_tx.eof <= 1'b1;
              cnt        <= '0;
              state      <= GAP;
            end else begin
              state <= PAD;
            end
          end
        end
        PAD: begin
          phy_tx.dat <= 8'h00;
          pcnt       <= pcnt + 11'd1;
          if (pcnt == 11'(MIN_PAYLOAD - 1)) begin
            phy_tx.eof <= 1'b1;
            cnt        <= '0;
            state      <= GAP;
          end
        end
        GAP: begin
          phy_tx.val <= 1'b0;
          done       <= (cnt == 4'd0); // First cycle after the last byte
          cnt        <= cnt + 4'd1;
          if (cnt == 4'(GAP_LEN - 1)) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Sources may not pause inside a frame
  a_payload_val: assert property (@(posedge clk) disable iff (rst)
    (state == PAYLOAD) |-> strm.val)
    else $error("eth_tx: payload byte missing");

endmodule

//--- design/net_core.sv
`timescale 1ns/1ps

module net_core import net_pkg::*; #(
  parameter mac_addr_t MAC_ADDR = 48'h02_4E_45_54_00_01
) (
  input  logic      clk,
  input  logic      rst,
  input  strm_t     phy_rx,
  output strm_t     phy_tx,
  input  ipv4_t     ip_addr,
  input  logic      ip_set,
  output mac_meta_t user_rx_meta,
  output logic      user_rx_meta_val,
  output strm_t     user_rx_strm,
  input  mac_meta_t user_tx_meta,
  input  logic      user_tx_rdy,
  output logic      user_tx_req,
  input  strm_t     user_tx_strm,
  output logic      user_tx_done
);

  mac_meta_t  arp_meta;
  logic       arp_rdy;
  strm_t      arp_strm;

  mac_meta_t  src_meta [2]; // 0 is ARP, 1 is user
  strm_t      src_strm [2];
  logic [1:0] src_rdy;
  logic [1:0] src_req;
  logic [1:0] src_done;

  mac_meta_t  tx_meta;
  logic       tx_rdy;
  logic       tx_req;
  logic       tx_done;
  strm_t      tx_strm;

  assign src_meta[0] = arp_meta;
  assign src_meta[1] = user_tx_meta;
  assign src_strm[0] = arp_strm;
  assign src_strm[1] = user_tx_strm;
  assign src_rdy     = {user_tx_rdy, arp_rdy};
  assign user_tx_req  = src_req[1];
  assign user_tx_done = src_done[1];

  //////////////////////////////////////////////////////////////////////
  // Receive side feeds both the user and the ARP responder
  //////////////////////////////////////////////////////////////////////

  eth_rx #(
    .MAC_ADDR (MAC_ADDR)
  ) u_eth_rx (
    .clk      (clk),
    .rst      (rst),
    .phy_rx   (phy_rx),
    .meta     (user_rx_meta),
    .meta_val (user_rx_meta_val),
    .strm     (user_rx_strm)
  );

  arp_resp #(
    .MAC_ADDR (MAC_ADDR)
  ) u_arp_resp (
    .clk         (clk),
    .rst         (rst),
    .ip_addr     (ip_addr),
    .ip_set      (ip_set),
    .rx_meta     (user_rx_meta),
    .rx_meta_val (user_rx_meta_val),
    .rx_strm     (user_rx_strm),
    .req         (src_req[0]),
    .done        (src_done[0]),
    .tx_meta     (arp_meta),
    .rdy         (arp_rdy),
    .tx_strm     (arp_strm)
  );

  //////////////////////////////////////////////////////////////////////
  // Transmit side
  //////////////////////////////////////////////////////////////////////

  tx_arb #(
    .N (2)
  ) u_tx_arb (
    .clk      (clk),
    .rst      (rst),
    .src_meta (src_meta),
    .src_rdy  (src_rdy),
    .src_strm (src_strm),
    .req      (tx_req),
    .done     (tx_done),
    .src_req  (src_req),
    .src_done (src_done),
    .meta     (tx_meta),
    .rdy      (tx_rdy),
    .strm     (tx_strm)
  );

  eth_tx u_eth_tx (
    .clk    (clk),
    .rst    (rst),
    .meta   (tx_meta),
    .rdy    (tx_rdy),
    .strm   (tx_strm),
    .req    (tx_req),
    .done   (tx_done),
    .phy_tx (phy_tx)
  );

endmodule

//--- tests/tb_frames.svh
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

////////////////////////////////////////////////////////////////////////
// Scratch frame and expectation queues, frames kept as line bytes
////////////////////////////////////////////////////////////////////////

byte_t     frm_q[$];
byte_t     pay_q[$];
byte_t     exp_rx_dat[$];
int        exp_rx_len[$];
mac_meta_t exp_rx_meta[$];
bit        cand_ok[$];     // One entry per accepted frame
mac_addr_t cand_sha[$];
ipv4_t     cand_spa[$];
byte_t     exp_arp_dat[$];
int        exp_arp_len[$];
byte_t     exp_usr_dat[$];
int        exp_usr_len[$];

// Locally administered, never the device or broadcast
function automatic mac_addr_t rand_mac();
  return {8'h0A, 8'($urandom), 32'($urandom)};
endfunction

task automatic push_field(logic [47:0] v, int n);
  for (int i = n - 1; i >= 0; i--) frm_q.push_back(v[8*i +: 8]); // MSB first
endtask

task automatic frame_start(mac_meta_t m);
  frm_q.delete();
  repeat (PRE_LEN) frm_q.push_back(8'h55);
  frm_q.push_back(8'hD5);
  push_field(m.dst, 6);
  push_field(m.src, 6);
  push_field(m.etype, 2);
endtask

task automatic pad_frame();
  while (frm_q.size() < 8 + 14 + 46) frm_q.push_back(8'h00);
endtask

// ARP body into pay_q, zero padding of random length behind it
task automatic build_arp_request(logic [15:0] oper, ipv4_t tpa);
  frm_q.delete();
  push_field(16'h0001, 2);
  push_field(16'h0800, 2);
  push_field(8'd6, 1);
  push_field(8'd4, 1);
  push_field(oper, 2);
  push_field(rand_mac(), 6);
  push_field(32'($urandom), 4);
  push_field(48'h0, 6);
  push_field(tpa, 4);
  repeat ($urandom % 19) frm_q.push_back(8'h00);
  pay_q = frm_q;
endtask

// Receive side model for the frame held in pay_q
task automatic model_rx(mac_meta_t m);
  if (m.dst == MAC_ADDR || m.dst == ETH_BCAST) begin
    exp_rx_meta.push_back(m);
    exp_rx_len.push_back(pay_q.size());
    foreach (pay_q[i]) exp_rx_dat.push_back(pay_q[i]);
    cand_ok.push_back(m.etype == ETH_ARP && pay_q.size() >= 28 && ip_is_set &&
                      {pay_q[6], pay_q[7]} == 16'd1 &&
                      {pay_q[24], pay_q[25], pay_q[26], pay_q[27]} == DEV_IP);
    cand_sha.push_back({pay_q[8], pay_q[9], pay_q[10], pay_q[11], pay_q[12], pay_q[13]});
    cand_spa.push_back({pay_q[14], pay_q[15], pay_q[16], pay_q[17]});
  end
endtask

task automatic expect_arp_reply(mac_addr_t sha, ipv4_t spa);
  frame_start('{dst: sha, src: MAC_ADDR, etype: ETH_ARP});
  push_field(48'h0001_0800_0604, 6); // htype, ptype, sizes
  push_field(16'd2, 2);
  push_field(MAC_ADDR, 6);
  push_field(DEV_IP, 4);
  push_field(sha, 6);
  push_field(spa, 4);
  pad_frame();
  foreach (frm_q[i]) exp_arp_dat.push_back(frm_q[i]);
  exp_arp_len.push_back(frm_q.size());
endtask

task automatic expect_user_tx(mac_meta_t m);
  frame_start(m);
  foreach (pay_q[i]) frm_q.push_back(pay_q[i]);
  pad_frame();
  foreach (frm_q[i]) exp_usr_dat.push_back(frm_q[i]);
  exp_usr_len.push_back(frm_q.size());
endtask

`endif

//--- tests/tb_net_core.sv
`timescale 1ns/1ps

module tb_net_core import net_pkg::*; ();

  localparam mac_addr_t MAC_ADDR   = 48'h02_4E_45_54_00_01;
  localparam ipv4_t     DEV_IP     = 32'hC0A8_0A07;
  localparam int        NUM_FRAMES = 60;

  logic      clk;
  logic      rst;
  strm_t     phy_rx;
  strm_t     phy_tx;
  ipv4_t     ip_addr;
  logic      ip_set;
  mac_meta_t user_rx_meta;
  logic      user_rx_meta_val;
  strm_t     user_rx_strm;
  mac_meta_t user_tx_meta;
  logic      user_tx_rdy;
  logic      user_tx_req;
  strm_t     user_tx_strm;
  logic      user_tx_done;

  int        errs[3];         // Receive, transmit, control
  bit        ip_is_set;
  bit        arp_pend;        // Model of the single reply slot
  int        must_src = -1;
  int        rx_len;
  int        rx_idx;
  byte_t     tx_q[$];
  int        tx_gap;
  bit        tx_seen;
  int        usr_done_cnt;
  int        usr_total;
  bit        usr_busy;
  int        stim_bytes;
  int        cycles;
  mac_meta_t usr_meta[$];
  int        usr_len[$];
  byte_t     usr_dat[$];

  `include "tb_frames.svh"

  net_core #(
    .MAC_ADDR (MAC_ADDR)
  ) uut (
    .clk              (clk),
    .rst              (rst),
    .phy_rx           (phy_rx),
    .phy_tx           (phy_tx),
    .ip_addr          (ip_addr),
    .ip_set           (ip_set),
    .user_rx_meta     (user_rx_meta),
    .user_rx_meta_val (user_rx_meta_val),
    .user_rx_strm     (user_rx_strm),
    .user_tx_meta     (user_tx_meta),
    .user_tx_rdy      (user_tx_rdy),
    .user_tx_req      (user_tx_req),
    .user_tx_strm     (user_tx_strm),
    .user_tx_done     (user_tx_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_val(string sig, logic [111:0] exp, logic [111:0] act, int cat);
    assert (exp === act) else begin
      errs[cat]++;
      $display("[ERROR] %s expected %0h got %0h at %0t", sig, exp, act, $time);
    end
  endtask

  task automatic check_true(bit ok, string what, int cat);
    assert (ok) else begin
      errs[cat]++;
      $display("%0t: %s", $time, what);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////

  function automatic mac_addr_t pick_dst();
    case ($urandom % 4)
      0:       return MAC_ADDR;
      1, 2:    return ETH_BCAST;
      default: return rand_mac(); // Foreign address that the filter drops
    endcase
  endfunction

  task automatic send_rx(mac_meta_t m);
    byte_t line[$];
    model_rx(m);
    frame_start(m);
    foreach (pay_q[i]) frm_q.push_back(pay_q[i]);
    line = frm_q;
    stim_bytes += line.size();
    foreach (line[i]) begin
      @(negedge clk);
      phy_rx = '{dat: line[i], val: 1'b1, sof: 1'b0, eof: 1'b0};
    end
    @(negedge clk);
    phy_rx = '0;
    repeat (3 + $urandom % 6) @(negedge clk);
  endtask

  task automatic queue_user_frame();
    mac_meta_t m;
    m = '{dst: rand_mac(), src: rand_mac(), etype: 16'($urandom)};
    if (m.etype == ETH_ARP) m.etype = 16'h88B5;
    pay_q.delete();
    repeat (1 + $urandom % 80) pay_q.push_back(8'($urandom));
    expect_user_tx(m);
    usr_meta.push_back(m);
    usr_len.push_back(pay_q.size());
    foreach (pay_q[i]) usr_dat.push_back(pay_q[i]);
    stim_bytes += pay_q.size();
    usr_total++;
  endtask

  // Frame source 1 following the rdy/req/done rule
  initial begin
    int n;
    forever begin
      @(negedge clk);
      if (!rst && usr_len.size() > 0) begin
        usr_busy     = 1'b1;
        n            = usr_len.pop_front();
        user_tx_meta = usr_meta.pop_front();
        user_tx_rdy  = 1'b1;
        do @(negedge clk); while (!user_tx_req);
        for (int k = 0; k < n; k++) begin
          @(negedge clk);
          user_tx_rdy  = 1'b0;
          user_tx_strm = '{dat: usr_dat.pop_front(), val: 1'b1, sof: k == 0, eof: k == n - 1};
        end
        @(negedge clk);
        user_tx_strm = '0;
        do @(negedge clk); while (!user_tx_done);
        usr_busy = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Monitors sample mid-cycle once inputs have settled
  ////////////////////////////////////////////////////////////////////////

  task automatic arp_request_done();
    bit ok;
    mac_addr_t sha;
    ipv4_t spa;
    if (cand_ok.size() == 0) return;
    ok  = cand_ok.pop_front();
    sha = cand_sha.pop_front();
    spa = cand_spa.pop_front();
    if (ok && !arp_pend) begin // Dropped while a reply is pending
      expect_arp_reply(sha, spa);
      arp_pend = 1'b1;
    end
  endtask

  task automatic compare_frame(bit arp, int n);
    byte_t e;
    for (int i = 0; i < n; i++) begin
      e = arp ? exp_arp_dat.pop_front() : exp_usr_dat.pop_front();
      if (i < tx_q.size()) check_val("phy_tx.dat", e, tx_q[i], 1);
    end
    check_val("phy_tx frame length", n, tx_q.size(), 1);
  endtask

  task automatic check_tx_frame();
    bit arp;
    int src;
    mac_addr_t sa;
    sa  = '0;
    arp = 1'b0;
    if (tx_q.size() >= 22) begin
      for (int i = 14; i < 20; i++) sa = {sa[39:0], tx_q[i]};
      arp = ({tx_q[20], tx_q[21]} == ETH_ARP) && (sa == MAC_ADDR);
    end
    src = arp ? 0 : 1;
    check_true(must_src < 0 || src == must_src, "frame order on phy_tx is not round robin", 2);
    if (arp) begin
      check_true(exp_arp_len.size() > 0, "ARP reply on phy_tx that no request called for", 1);
      if (exp_arp_len.size() > 0) compare_frame(1'b1, exp_arp_len.pop_front());
      arp_pend = 1'b0;
      must_src = user_tx_rdy ? 1 : -1;
    end else begin
      check_true(exp_usr_len.size() > 0, "user frame on phy_tx that was never sent", 1);
      if (exp_usr_len.size() > 0) compare_frame(1'b0, exp_usr_len.pop_front());
      must_src = arp_pend ? 0 : -1;
    end
  endtask

  always @(negedge clk) begin
    #1;
    if (rst) begin
      check_val("phy_tx.val,user_tx_req,user_tx_done,user_rx_meta_val", 4'h0,
                {phy_tx.val, user_tx_req, user_tx_done, user_rx_meta_val}, 2);
    end else begin
      if (user_tx_done) usr_done_cnt++;
      if (user_rx_meta_val) begin
        check_true(exp_rx_len.size() > 0, "user_rx frame that should have been filtered", 0);
        if (exp_rx_len.size() > 0) begin
          check_val("user_rx_meta", exp_rx_meta.pop_front(), user_rx_meta, 0);
          rx_len = exp_rx_len.pop_front();
          rx_idx = 0;
        end
      end
      if (user_rx_strm.val) begin
        check_true(exp_rx_dat.size() > 0, "user_rx_strm byte with nothing expected", 0);
        if (exp_rx_dat.size() > 0) check_val("user_rx_strm.dat", exp_rx_dat.pop_front(),
                                             user_rx_strm.dat, 0);
        check_val("user_rx_strm.sof", rx_idx == 0, user_rx_strm.sof, 0);
        check_val("user_rx_strm.eof", rx_idx == rx_len - 1, user_rx_strm.eof, 0);
        rx_idx++;
        if (user_rx_strm.eof) arp_request_done(); // Runs ahead of tx, slot frees after done
      end
      if (phy_tx.val) begin
        if (tx_q.size() == 0 && tx_seen) check_true(tx_gap >= 12, "interframe gap too short", 1);
        tx_q.push_back(phy_tx.dat);
        tx_gap = 0;
      end else begin
        if (tx_q.size() > 0) begin
          check_tx_frame();
          tx_q.delete();
          tx_seen = 1'b1;
        end
        tx_gap++;
      end
    end
  end

  // Watchdog limit grows with the stimulus
  initial begin
    cycles = 0;
    while (cycles <= 40 * stim_bytes + 2000) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, expected frames never completed", cycles);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin
    mac_meta_t m;
    void'($urandom(83));
    rst          = 1'b1;
    phy_rx       = '0;
    ip_addr      = '0;
    ip_set       = 1'b0;
    user_tx_meta = '0;
    user_tx_rdy  = 1'b0;
    user_tx_strm = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    // Matching request with no address loaded yet
    build_arp_request(16'd1, DEV_IP);
    send_rx('{dst: ETH_BCAST, src: rand_mac(), etype: ETH_ARP});
    // Target equals the cleared stored address
    build_arp_request(16'd1, '0);
    send_rx('{dst: ETH_BCAST, src: rand_mac(), etype: ETH_ARP});
    repeat (100) @(negedge clk);
    ip_addr   = DEV_IP;
    ip_set    = 1'b1;
    ip_is_set = 1'b1;
    @(negedge clk);
    ip_set = 1'b0;

    for (int f = 0; f < NUM_FRAMES; f++) begin
      if ($urandom % 3 == 0) queue_user_frame();
      if ($urandom % 3 == 0) begin
        build_arp_request(($urandom % 5 == 0) ? 16'd2 : 16'd1,
                          ($urandom % 4 == 0) ? 32'($urandom) : DEV_IP);
        m = '{dst: pick_dst(), src: rand_mac(), etype: ETH_ARP};
      end else begin
        pay_q.delete();
        repeat (1 + $urandom % 80) pay_q.push_back(8'($urandom));
        m = '{dst: pick_dst(), src: rand_mac(), etype: 16'($urandom)};
        if (m.etype == ETH_ARP) m.etype = 16'h86DD;
      end
      send_rx(m);
    end

    while (exp_arp_len.size() != 0 || exp_usr_len.size() != 0 || usr_len.size() != 0 ||
           usr_busy) @(negedge clk);
    // Room for one more padded frame behind an interframe gap
    repeat (2 * (PRE_LEN + 1 + HDR_LEN + MIN_PAYLOAD)) @(negedge clk);
    check_true(exp_rx_len.size() == 0 && exp_rx_dat.size() == 0,
               "accepted frames missing on user_rx", 0);
    check_val("user_tx_done count", usr_total, usr_done_cnt, 2);

    $display("Errors: receive %0d, transmit %0d, control %0d", errs[0], errs[1], errs[2]);
    if (errs[0] + errs[1] + errs[2] == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- all.f
+incdir+tests
design/net_pkg.sv
design/eth_rx.sv
design/arp_resp.sv
design/tx_arb.sv
design/eth_tx.sv
design/net_core.sv
tests/tb_net_core.sv
